/* verilog/linebuf_pkg.sv */
`default_nettype none

package linebuf_pkg;

  localparam int MAXFIL    = 3;
  localparam int MAXIMG    = 32;
  localparam int DWIDTH    = 16;
  localparam int LWIDTH    = 8;
  localparam int BUFLINE   = MAXFIL + 1;
  localparam int SIZEWIDTH = $clog2(MAXIMG) + 1;
  localparam int LINEWIDTH = $clog2(BUFLINE);
  localparam int MEMDELAY  = 1;

  typedef struct packed {
    logic [LWIDTH-1:0] size;
    logic [LWIDTH-1:0] kern;
    logic [LWIDTH-1:0] strid;
    logic [LWIDTH-1:0] pad;
  } conv_cfg_t;

  // line numbers are one based, zero selects no line
  typedef struct packed {
    logic                 we;
    logic [SIZEWIDTH-1:0] addr;
    logic [LINEWIDTH:0]   wsel;
    logic [LINEWIDTH:0]   rsel;
    logic [MAXFIL-1:0]    rrow;
  } buf_sel_t;

  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } win_strobe_t;

  // pix[i][j] is kernel row i, column j
  typedef struct packed {
    logic [MAXFIL-1:0][MAXFIL-1:0][DWIDTH-1:0] pix;
  } window_t;

endpackage

`default_nettype wire

/* verilog/linebuf_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module linebuf_ctrl
  import linebuf_pkg::*;
  ( input  wire              clk
  , input  wire              xrst
  , input  wire conv_cfg_t   cfg
  , input  wire              req
  , output logic             ack
  , output logic             ready
  , output buf_sel_t         sel
  , output win_strobe_t      strb
  );

  typedef enum logic [1:0] {
    S_WAIT,
    S_CHARGE,
    S_ACTIVE
  } state_t;

  state_t                         state;
  logic [2:0]                     ack_d;
  logic [LWIDTH-1:0]              side;
  logic [LWIDTH-1:0]              col;
  logic [LWIDTH-1:0]              row;
  logic [LWIDTH-1:0]              str_x;
  logic [LWIDTH-1:0]              str_y;
  logic [LINEWIDTH-1:0]           wline;
  logic [LINEWIDTH-1:0]           rline;
  logic                           col_last;
  logic                           charge_end;
  logic                           active_end;
  logic                           in_row;
  logic                           in_col;
  logic                           vld0;
  logic [MAXFIL-1:0]              rrow0;
  win_strobe_t                    strb0;
  logic                           we_q;
  logic [SIZEWIDTH-1:0]           addr_q;
  logic [LINEWIDTH:0]             wsel_q;
  logic [LINEWIDTH:0]             rsel_q;
  logic [MEMDELAY:0][MAXFIL-1:0]  rrow_d;
  win_strobe_t [MEMDELAY:0]       strb_d;

// ==========================================================================
// state machine
// ==========================================================================

  // padded side, no cover-all
  assign side       = cfg.size + (cfg.pad << 1);
  assign col_last   = col == side - 1'b1;
  assign charge_end = state == S_CHARGE && row == cfg.kern - 1'b1 && col_last;
  // one extra row sweep reads out the last padded row
  assign active_end = state == S_ACTIVE && row == side && col_last;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
    end else begin
      case (state)
        S_WAIT: begin
          if (req && ack) begin
            state <= S_CHARGE;
          end
        end
        S_CHARGE: begin
          if (charge_end) begin
            state <= S_ACTIVE;
          end
        end
        S_ACTIVE: begin
          if (active_end) begin
            state <= S_WAIT;
          end
        end
        default: begin
          state <= S_WAIT;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack_d <= '0;
    end else begin
      ack_d <= {ack_d[1:0], state == S_WAIT};
    end
  end

  assign ack = state == S_WAIT && ack_d[2];

// ==========================================================================
// counters
// ==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col   <= '0;
      row   <= '0;
      str_x <= '0;
      str_y <= '0;
      wline <= '0;
      rline <= '0;
    end else if (state == S_WAIT) begin
      col   <= '0;
      row   <= '0;
      str_x <= '0;
      str_y <= '0;
      wline <= '0;
      // first read line trails the write line by kern rows
      rline <= LINEWIDTH'(BUFLINE - cfg.kern);
    end else begin
      col <= col_last ? '0 : col + 1'b1;
      // stride phase starts once a full kernel of columns is in
      if (col < cfg.kern - 1'b1 || col_last || str_x == cfg.strid - 1'b1) begin
        str_x <= '0;
      end else begin
        str_x <= str_x + 1'b1;
      end
      if (col_last) begin
        row   <= row + 1'b1;
        wline <= (wline == LINEWIDTH'(BUFLINE - 1)) ? '0 : wline + 1'b1;
        rline <= (rline == LINEWIDTH'(BUFLINE - 1)) ? '0 : rline + 1'b1;
        if (row < cfg.kern || str_y == cfg.strid - 1'b1) begin
          str_y <= '0;
        end else begin
          str_y <= str_y + 1'b1;
        end
      end
    end
  end

// ==========================================================================
// selects and strobes
// ==========================================================================

  assign in_row = row >= cfg.pad && row < cfg.size + cfg.pad;
  assign in_col = col >= cfg.pad && col < cfg.size + cfg.pad;
  assign ready  = state != S_WAIT && in_row && in_col;

  // padded rows and columns read as zero through the mask
  for (genvar i = 0; i < MAXFIL; i++) begin : g_rrow
    assign rrow0[i] = in_col && LWIDTH'(i) < cfg.kern
                   && row + LWIDTH'(i) >= cfg.pad + cfg.kern
                   && row + LWIDTH'(i) < cfg.size + cfg.pad + cfg.kern;
  end

  assign vld0  = state == S_ACTIVE && col >= cfg.kern - 1'b1
              && str_x == '0 && str_y == '0;
  assign strb0 = '{
    start: vld0 && row == cfg.kern && col == cfg.kern - 1'b1,
    valid: vld0,
    stop:  vld0 && row + cfg.strid > side && col + cfg.strid >= side
  };

  always_ff @(posedge clk) begin
    if (!xrst) begin
      we_q   <= 1'b0;
      addr_q <= '0;
      wsel_q <= '0;
      rsel_q <= '0;
    end else begin
      we_q   <= ready;
      addr_q <= in_col ? SIZEWIDTH'(col - cfg.pad) : '0;
      wsel_q <= ready ? {1'b0, wline} + 1'b1 : '0;
      rsel_q <= (state == S_WAIT) ? '0 : {1'b0, rline} + 1'b1;
    end
  end

  // mask and strobes wait out the memory read
  always_ff @(posedge clk) begin
    if (!xrst) begin
      rrow_d <= '0;
      strb_d <= '0;
    end else begin
      rrow_d[0] <= rrow0;
      strb_d[0] <= strb0;
      for (int k = 1; k <= MEMDELAY; k++) begin
        rrow_d[k] <= rrow_d[k-1];
        strb_d[k] <= strb_d[k-1];
      end
    end
  end

  assign sel = '{
    we:   we_q,
    addr: addr_q,
    wsel: wsel_q,
    rsel: rsel_q,
    rrow: rrow_d[MEMDELAY]
  };
  assign strb = strb_d[MEMDELAY];

endmodule

`default_nettype wire

/* verilog/linebuf_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module linebuf_mem
  import linebuf_pkg::*;
  ( input  wire                            clk
  , input  wire                            xrst
  , input  wire [DWIDTH-1:0]               pixel
  , input  wire buf_sel_t                  sel
  , output logic [MAXFIL-1:0][DWIDTH-1:0]  rows
  );

  logic [DWIDTH-1:0]          line_mem [BUFLINE][MAXIMG];
  logic [DWIDTH-1:0]          pixel_q;
  logic [$clog2(MAXIMG)-1:0]  col;
  logic [LINEWIDTH:0]         wline;
  logic [LINEWIDTH:0]         rline [MAXFIL];

  assign col   = sel.addr[$clog2(MAXIMG)-1:0];
  assign wline = sel.wsel - 1'b1;

  // consecutive read lines, wrapping over the bank
  for (genvar i = 0; i < MAXFIL; i++) begin : g_rline
    logic [LINEWIDTH:0] rsum;

    assign rsum     = sel.rsel + (LINEWIDTH+1)'(i) - 1'b1;
    assign rline[i] = (rsum >= (LINEWIDTH+1)'(BUFLINE))
                    ? rsum - (LINEWIDTH+1)'(BUFLINE)
                    : rsum;
  end

// ==========================================================================
// write port
// ==========================================================================

  // select is registered in ctrl, so the pixel is held one cycle
  always_ff @(posedge clk) begin
    pixel_q <= pixel;
    if (sel.we && sel.wsel != '0) begin
      line_mem[wline[LINEWIDTH-1:0]][col] <= pixel_q;
    end
  end

// ==========================================================================
// read ports
// ==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      rows <= '0;
    end else begin
      for (int i = 0; i < MAXFIL; i++) begin
        rows[i] <= line_mem[rline[i][LINEWIDTH-1:0]][col];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/window_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module window_shift
  import linebuf_pkg::*;
  ( input  wire                            clk
  , input  wire                            xrst
  , input  wire [MAXFIL-1:0][DWIDTH-1:0]   rows
  , input  wire [MAXFIL-1:0]               rrow
  , input  wire win_strobe_t               strb_in
  , input  wire [LWIDTH-1:0]               kern
  , output window_t                        win
  , output win_strobe_t                    strb
  );

  logic [MAXFIL-1:0][DWIDTH-1:0]              cur;
  logic [MAXFIL-2:0][MAXFIL-1:0][DWIDTH-1:0]  hist;
  window_t                                    win_d;

  // top and bottom padding
  for (genvar i = 0; i < MAXFIL; i++) begin : g_mask
    assign cur[i] = rrow[i] ? rows[i] : '0;
  end

  // hist[0] is the previous column
  always_ff @(posedge clk) begin
    hist[0] <= cur;
    for (int k = 1; k < MAXFIL - 1; k++) begin
      hist[k] <= hist[k-1];
    end
  end

// ==========================================================================
// window assembly
// ==========================================================================

  // column j of a kern-wide window sits kern-1-j columns back
  always_comb begin
    int back;

    win_d = '0;
    for (int i = 0; i < MAXFIL; i++) begin
      for (int j = 0; j < MAXFIL; j++) begin
        back = int'(kern) - 1 - j;
        if (i < int'(kern) && back >= 0 && back < MAXFIL) begin
          if (back == 0) begin
            win_d.pix[i][j] = cur[i];
          end else begin
            win_d.pix[i][j] = hist[back-1][i];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    win <= win_d;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      strb <= '0;
    end else begin
      strb <= strb_in;
    end
  end

endmodule

`default_nettype wire

/* verilog/linebuf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module linebuf_top
  import linebuf_pkg::*;
  ( input  wire                clk
  , input  wire                xrst
  , input  wire conv_cfg_t     cfg
  , input  wire                req
  , input  wire [DWIDTH-1:0]   pixel
  , output wire                ack
  , output wire                ready
  , output window_t            win
  , output win_strobe_t        strb
  );

  buf_sel_t                       sel;
  win_strobe_t                    strb_mid;
  logic [MAXFIL-1:0][DWIDTH-1:0]  rows;

  linebuf_ctrl u_ctrl
    ( .clk    (clk)
    , .xrst   (xrst)
    , .cfg    (cfg)
    , .req    (req)
    , .ack    (ack)
    , .ready  (ready)
    , .sel    (sel)
    , .strb   (strb_mid)
    );

  linebuf_mem u_mem
    ( .clk    (clk)
    , .xrst   (xrst)
    , .pixel  (pixel)
    , .sel    (sel)
    , .rows   (rows)
    );

  // mask is already aligned with rows inside sel
  window_shift u_window
    ( .clk      (clk)
    , .xrst     (xrst)
    , .rows     (rows)
    , .rrow     (sel.rrow)
    , .strb_in  (strb_mid)
    , .kern     (cfg.kern)
    , .win      (win)
    , .strb     (strb)
    );

endmodule

`default_nettype wire

/* tb/linebuf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module linebuf_tb
  import linebuf_pkg::*;
  ();

  localparam int NFRAME = 10;

  logic              clk = 1'b0;
  logic              xrst;
  conv_cfg_t         cfg;
  logic              req;
  logic [DWIDTH-1:0] pixel;
  logic              ack;
  logic              ready;
  window_t           win;
  win_strobe_t       strb;

  conv_cfg_t         frames [NFRAME];
  logic [DWIDTH-1:0] img [MAXIMG*MAXIMG];
  logic [31:0]       rnd;
  window_t           exp_win;
  int                out_side;
  int                exp_valids;
  int                exp_readies;
  int                limit;
  int                cyc       = 0;
  int                rel_cyc   = 0;
  int                nvalid    = 0;
  int                nready    = 0;
  logic              launched  = 1'b0;
  logic              busy      = 1'b0;
  logic              stop_seen = 1'b0;

  linebuf_top UUT
    ( .clk    (clk)
    , .xrst   (xrst)
    , .cfg    (cfg)
    , .req    (req)
    , .pixel  (pixel)
    , .ack    (ack)
    , .ready  (ready)
    , .win    (win)
    , .strb   (strb)
    );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // window idx in raster order, padding and unused kernel taps are zero
  function automatic window_t window_at(input int idx);
    window_t w;
    int      sz;
    int      r;
    int      c;
    int      y;
    int      x;

    w  = '0;
    sz = int'(cfg.size);
    r  = idx / out_side;
    c  = idx % out_side;
    for (int i = 0; i < MAXFIL; i++) begin
      for (int j = 0; j < MAXFIL; j++) begin
        y = int'(cfg.strid) * r - int'(cfg.pad) + i;
        x = int'(cfg.strid) * c - int'(cfg.pad) + j;
        if (i < int'(cfg.kern) && j < int'(cfg.kern)
            && y >= 0 && y < sz && x >= 0 && x < sz) begin
          w.pix[i][j] = img[y * sz + x];
        end
      end
    end
    return w;
  endfunction

  task automatic report_error(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_value(input string name,
                              input logic [MAXFIL*MAXFIL*DWIDTH-1:0] expected,
                              input logic [MAXFIL*MAXFIL*DWIDTH-1:0] actual);
    report_error($sformatf("FAILED %s: expected %0h, actual %0h",
                           name, expected, actual));
  endtask

  always_comb begin
    out_side    = (int'(cfg.size) + 2 * int'(cfg.pad) - int'(cfg.kern))
                / int'(cfg.strid) + 1;
    exp_valids  = out_side * out_side;
    exp_readies = int'(cfg.size) * int'(cfg.size);
  end

// ==========================================================================
// pixel feed and frame bookkeeping
// ==========================================================================

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (xrst && rel_cyc < 8) begin
      rel_cyc <= rel_cyc + 1;
    end
    if (req && ack) begin
      launched  <= 1'b1;
      busy      <= 1'b1;
      stop_seen <= 1'b0;
      nvalid    <= 0;
      nready    <= 0;
      pixel     <= img[0];
      exp_win   <= window_at(0);
    end else begin
      if (busy && ack) begin
        busy <= 1'b0;
      end
      // ready is a take-now strobe, so move on to the next pixel
      if (ready) begin
        nready <= nready + 1;
        pixel  <= img[nready + 1];
      end
      if (strb.valid) begin
        nvalid  <= nvalid + 1;
        exp_win <= window_at(nvalid + 1);
      end
      if (strb.stop) begin
        stop_seen <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    if (cyc >= limit) begin
      report_error($sformatf("timeout after %0d cycles without finishing", limit));
    end
  end

// ==========================================================================
// checks
// ==========================================================================

  a_idle: assert property (@(posedge clk) disable iff (!xrst)
    !launched |-> !strb.valid && !strb.start && !strb.stop && !ready)
    else report_error("strobe or ready active before the first frame");
  a_ack_up: assert property (@(posedge clk) disable iff (!xrst)
    rel_cyc == 4 |-> ack)
    else report_error("ack not high by the fourth cycle after reset");
  a_window: assert property (@(posedge clk) disable iff (!xrst)
    strb.valid |-> win == exp_win)
    else report_value("window", $sampled(exp_win), $sampled(win));
  a_start: assert property (@(posedge clk) disable iff (!xrst)
    strb.valid |-> strb.start == (nvalid == 0))
    else report_value("start", $sampled(nvalid == 0), $sampled(strb.start));
  a_stop: assert property (@(posedge clk) disable iff (!xrst)
    strb.valid |-> strb.stop == (nvalid + 1 == exp_valids))
    else report_value("stop", $sampled(nvalid + 1 == exp_valids),
                      $sampled(strb.stop));
  a_marker: assert property (@(posedge clk) disable iff (!xrst)
    strb.start || strb.stop |-> strb.valid)
    else report_error("start or stop without valid");
  a_span: assert property (@(posedge clk) disable iff (!xrst)
    strb.valid |-> busy && !stop_seen)
    else report_error("valid outside the start to stop span");
  a_ack_low: assert property (@(posedge clk) disable iff (!xrst)
    busy && !stop_seen |-> !ack)
    else report_error("ack high while a frame is in progress");
  a_nvalid: assert property (@(posedge clk) disable iff (!xrst)
    busy && ack |-> nvalid == exp_valids)
    else report_value("valid count", $sampled(exp_valids), $sampled(nvalid));
  a_nready: assert property (@(posedge clk) disable iff (!xrst)
    busy && ack |-> nready == exp_readies)
    else report_value("ready count", $sampled(exp_readies), $sampled(nready));

// ==========================================================================
// frame sequence
// ==========================================================================

  initial begin
    logic [2:0] pick;
    int         side;

    rnd   = 32'haded9019;
    limit = 200;
    // first eight frames cover every kern, pad and stride pairing
    for (int f = 0; f < NFRAME; f++) begin
      rnd  = lcg_next(rnd);
      pick = (f < 8) ? 3'(f) : rnd[29:27];
      frames[f].size  = LWIDTH'(4 + rnd[23:16] % 5);
      frames[f].kern  = pick[0] ? 8'd3 : 8'd1;
      frames[f].pad   = {7'd0, pick[1]};
      frames[f].strid = pick[2] ? 8'd2 : 8'd1;
      side  = int'(frames[f].size) + 2 * int'(frames[f].pad) + 2;
      limit = limit + 4 * side * side;
    end

    cfg   = frames[0];
    req   = 1'b0;
    pixel = '0;
    xrst  = 1'b0;
    repeat (3) @(posedge clk);
    xrst <= 1'b1;

    for (int f = 0; f < NFRAME; f++) begin
      @(posedge clk);
      while (!ack) begin
        @(posedge clk);
      end
      for (int n = 0; n < MAXIMG * MAXIMG; n++) begin
        rnd    = lcg_next(rnd);
        img[n] = rnd[31:16];
      end
      cfg <= frames[f];
      req <= 1'b1;
      @(posedge clk);
      req <= 1'b0;
    end

    @(posedge clk);
    while (!ack) begin
      @(posedge clk);
    end
    // one more edge so the end-of-frame counts get checked
    @(posedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
verilog/linebuf_pkg.sv
verilog/linebuf_ctrl.sv
verilog/linebuf_mem.sv
verilog/window_shift.sv
verilog/linebuf_top.sv
tb/linebuf_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the line buffer testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module linebuf_tb -o linebuf_sim

# the simulator exits non-zero on $fatal, the log decides the result
./obj_dir/linebuf_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
grep -q "Result: PASSED" sim.log
